// ==== design/scb_entry.sv ====
module scb_entry (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_en_i,
    input  scb_pkg::reg_idx_t wr_rd_i,
    input  scb_pkg::reg_idx_t wr_rs1_i,
    input  scb_pkg::reg_idx_t wr_rs2_i,
    input  scb_pkg::sid_t     wr_sid_i,
    input  logic              wb_vld_0_i,
    input  scb_pkg::sid_t     wb_sid_0_i,
    input  logic              wb_vld_1_i,
    input  scb_pkg::sid_t     wb_sid_1_i,
    input  logic              redirect_i,
    input  scb_pkg::sid_t     redirect_sid_i,
    output logic              busy_o,
    output scb_pkg::reg_idx_t rd_o,
    output scb_pkg::sid_t     sid_o
);

    logic              busy_q;
    scb_pkg::reg_idx_t rd_q;
    scb_pkg::sid_t     sid_q;
    logic              flush;
    logic              wb_hit;
    logic              free_en;

    assign flush   = redirect_i && scb_pkg::is_younger(sid_q, redirect_sid_i);
    assign wb_hit  = (wb_vld_0_i && wb_sid_0_i == sid_q) || (wb_vld_1_i && wb_sid_1_i == sid_q);
    // a stale sid in a free entry must not block a new write
    assign free_en = busy_q && (flush || wb_hit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (free_en) begin
            busy_q <= 1'b0;
        end else if (wr_en_i) begin
            busy_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            rd_q  <= wr_rd_i;
            sid_q <= wr_sid_i;
        end
    end

    assign busy_o = busy_q;
    assign rd_o   = rd_q;
    assign sid_o  = sid_q;

    // issue steering only ever picks a free slot
    a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en_i |-> !busy_q || free_en);

endmodule

// ==== design/scb_issue.sv ====
`include "scb_consts.svh"

module scb_issue (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   dec_vld_0_i,
    input  scb_pkg::exe_sel_t                      dec_exe_sel_0_i,
    input  scb_pkg::reg_idx_t                      dec_rd_0_i,
    input  scb_pkg::reg_idx_t                      dec_rs1_0_i,
    input  scb_pkg::reg_idx_t                      dec_rs2_0_i,
    input  logic                                   dec_vld_1_i,
    input  scb_pkg::exe_sel_t                      dec_exe_sel_1_i,
    input  scb_pkg::reg_idx_t                      dec_rd_1_i,
    input  scb_pkg::reg_idx_t                      dec_rs1_1_i,
    input  scb_pkg::reg_idx_t                      dec_rs2_1_i,
    input  scb_pkg::unit_vec_t                     busy_i,
    input  scb_pkg::reg_idx_t [`SCB_NUM_UNITS-1:0] ent_rd_i,
    input  logic                                   redirect_i,
    input  scb_pkg::sid_t                          redirect_sid_i,
    output logic                                   dec_stall_0_o,
    output logic                                   dec_flush_0_o,
    output scb_pkg::sid_t                          dec_sid_0_o,
    output scb_pkg::unit_vec_t                     dec_unit_0_o,
    output logic                                   dec_stall_1_o,
    output logic                                   dec_flush_1_o,
    output scb_pkg::sid_t                          dec_sid_1_o,
    output scb_pkg::unit_vec_t                     dec_unit_1_o,
    output scb_pkg::unit_vec_t                     wr_en_o,
    output scb_pkg::unit_vec_t                     wr_lane_o,
    output scb_pkg::reg_idx_t                      wr_rd_0_o,
    output scb_pkg::reg_idx_t                      wr_rs1_0_o,
    output scb_pkg::reg_idx_t                      wr_rs2_0_o,
    output scb_pkg::sid_t                          wr_sid_0_o,
    output scb_pkg::reg_idx_t                      wr_rd_1_o,
    output scb_pkg::reg_idx_t                      wr_rs1_1_o,
    output scb_pkg::reg_idx_t                      wr_rs2_1_o,
    output scb_pkg::sid_t                          wr_sid_1_o
);

    scb_pkg::sid_t      sid_q;
    scb_pkg::unit_vec_t waw_hit_0;
    scb_pkg::unit_vec_t waw_hit_1;
    scb_pkg::unit_vec_t cand_0;
    scb_pkg::unit_vec_t cand_1;
    scb_pkg::unit_vec_t unit_0;
    scb_pkg::unit_vec_t unit_1;
    scb_pkg::unit_vec_t occ_1;
    logic               same_rd;
    logic               take_0;
    logic               take_1;

    // alu0 first, alu1 only once alu0 is taken
    function automatic scb_pkg::unit_vec_t pick_unit(input logic               vld,
                                                     input scb_pkg::exe_sel_t  sel,
                                                     input scb_pkg::unit_vec_t occ);
        scb_pkg::unit_vec_t u;
        u[`SCB_U_ALU0] = vld && sel[`SCB_SEL_ALU] && !occ[`SCB_U_ALU0];
        u[`SCB_U_ALU1] = vld && sel[`SCB_SEL_ALU] && occ[`SCB_U_ALU0] && !occ[`SCB_U_ALU1];
        u[`SCB_U_BEU]  = vld && sel[`SCB_SEL_BEU] && !occ[`SCB_U_BEU];
        u[`SCB_U_LSU]  = vld && sel[`SCB_SEL_LSU] && !occ[`SCB_U_LSU];
        return u;
    endfunction

    for (genvar u = 0; u < `SCB_NUM_UNITS; u++) begin : g_waw
        assign waw_hit_0[u] = busy_i[u] && ent_rd_i[u] == dec_rd_0_i;
        assign waw_hit_1[u] = busy_i[u] && ent_rd_i[u] == dec_rd_1_i;
    end

    assign cand_0        = pick_unit(dec_vld_0_i, dec_exe_sel_0_i, busy_i);
    assign unit_0        = (|waw_hit_0) ? '0 : cand_0;
    assign dec_stall_0_o = dec_vld_0_i && !(|unit_0);

    // lane 1 sees the slot lane 0 is about to fill
    assign occ_1         = busy_i | unit_0;
    assign cand_1        = pick_unit(dec_vld_1_i, dec_exe_sel_1_i, occ_1);
    assign same_rd       = dec_vld_0_i && dec_rd_0_i == dec_rd_1_i;
    assign unit_1        = (|waw_hit_1 || same_rd || dec_stall_0_o) ? '0 : cand_1;
    assign dec_stall_1_o = dec_vld_1_i && !(|unit_1);

    assign dec_unit_0_o = unit_0;
    assign dec_unit_1_o = unit_1;
    assign dec_sid_0_o  = sid_q;
    assign dec_sid_1_o  = sid_q + 1'b1;

    assign dec_flush_0_o = redirect_i && scb_pkg::is_younger(dec_sid_0_o, redirect_sid_i);
    assign dec_flush_1_o = redirect_i && scb_pkg::is_younger(dec_sid_1_o, redirect_sid_i);

    // flushed lanes do not reach an entry
    assign take_0    = (|unit_0) && !dec_flush_0_o;
    assign take_1    = (|unit_1) && !dec_flush_1_o;
    assign wr_en_o   = ({`SCB_NUM_UNITS{take_0}} & unit_0) | ({`SCB_NUM_UNITS{take_1}} & unit_1);
    assign wr_lane_o = {`SCB_NUM_UNITS{take_1}} & unit_1;

    assign wr_rd_0_o  = dec_rd_0_i;
    assign wr_rs1_0_o = dec_rs1_0_i;
    assign wr_rs2_0_o = dec_rs2_0_i;
    assign wr_sid_0_o = dec_sid_0_o;
    assign wr_rd_1_o  = dec_rd_1_i;
    assign wr_rs1_1_o = dec_rs1_1_i;
    assign wr_rs2_1_o = dec_rs2_1_i;
    assign wr_sid_1_o = dec_sid_1_o;

    // lane 1 on its own still holds sid_q+1, so step past it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sid_q <= '0;
        end else if (take_1) begin
            sid_q <= sid_q + 2'd2;
        end else if (take_0) begin
            sid_q <= sid_q + 1'b1;
        end
    end

endmodule

// ==== design/scb_operand_hazard.sv ====
`include "scb_consts.svh"

module scb_operand_hazard (
    input  logic                                   op_vld_0_i,
    input  scb_pkg::sid_t                          op_sid_0_i,
    input  scb_pkg::reg_idx_t                      op_rd_0_i,
    input  scb_pkg::reg_idx_t                      op_rs1_0_i,
    input  scb_pkg::reg_idx_t                      op_rs2_0_i,
    input  logic                                   op_vld_1_i,
    input  scb_pkg::sid_t                          op_sid_1_i,
    input  scb_pkg::reg_idx_t                      op_rd_1_i,
    input  scb_pkg::reg_idx_t                      op_rs1_1_i,
    input  scb_pkg::reg_idx_t                      op_rs2_1_i,
    input  scb_pkg::unit_vec_t                     busy_i,
    input  scb_pkg::reg_idx_t [`SCB_NUM_UNITS-1:0] ent_rd_i,
    input  scb_pkg::sid_t     [`SCB_NUM_UNITS-1:0] ent_sid_i,
    input  logic                                   redirect_i,
    input  scb_pkg::sid_t                          redirect_sid_i,
    output logic                                   op_stall_0_o,
    output logic                                   op_flush_0_o,
    output logic                                   op_stall_1_o,
    output logic                                   op_flush_1_o
);

    logic [1:0]              vld;
    scb_pkg::sid_t     [1:0] sid;
    scb_pkg::reg_idx_t [1:0] rd;
    scb_pkg::reg_idx_t [1:0] rs1;
    scb_pkg::reg_idx_t [1:0] rs2;
    logic [1:0]              stall;
    logic [1:0]              flush;

    assign vld = {op_vld_1_i, op_vld_0_i};
    assign sid = {op_sid_1_i, op_sid_0_i};
    assign rd  = {op_rd_1_i, op_rd_0_i};
    assign rs1 = {op_rs1_1_i, op_rs1_0_i};
    assign rs2 = {op_rs2_1_i, op_rs2_0_i};

    for (genvar l = 0; l < 2; l++) begin : g_lane
        scb_pkg::unit_vec_t ent_raw;
        logic               lane_raw;

        // own entry has an equal sid and never matches
        for (genvar u = 0; u < `SCB_NUM_UNITS; u++) begin : g_ent
            assign ent_raw[u] = busy_i[u] && scb_pkg::is_younger(sid[l], ent_sid_i[u]) &&
                                (ent_rd_i[u] == rs1[l] || ent_rd_i[u] == rs2[l]);
        end

        // older instruction in the other operand lane
        assign lane_raw = vld[1-l] && scb_pkg::is_younger(sid[l], sid[1-l]) &&
                          (rd[1-l] == rs1[l] || rd[1-l] == rs2[l]);

        assign stall[l] = vld[l] && (|ent_raw || lane_raw);
        assign flush[l] = redirect_i && scb_pkg::is_younger(sid[l], redirect_sid_i);
    end

    assign op_stall_0_o = stall[0];
    assign op_stall_1_o = stall[1];
    assign op_flush_0_o = flush[0];
    assign op_flush_1_o = flush[1];

endmodule

// ==== design/scb_pkg.sv ====
`include "scb_consts.svh"

package scb_pkg;

    typedef logic [`SCB_SID_IDX_W:0]   sid_t;
    typedef logic [`SCB_REG_W-1:0]     reg_idx_t;
    typedef logic [`SCB_EXE_SEL_W-1:0] exe_sel_t;
    typedef logic [`SCB_NUM_UNITS-1:0] unit_vec_t;

    // true when a was issued after b
    // wrap bit toggles each time the index space rolls over
    function automatic logic is_younger(input sid_t a, input sid_t b);
        logic same_wrap;
        same_wrap = a[`SCB_SID_IDX_W] == b[`SCB_SID_IDX_W];
        if (same_wrap) begin
            return a[`SCB_SID_IDX_W-1:0] > b[`SCB_SID_IDX_W-1:0];
        end
        return a[`SCB_SID_IDX_W-1:0] < b[`SCB_SID_IDX_W-1:0];
    endfunction

endpackage

// ==== design/scoreboard_top.sv ====
`include "scb_consts.svh"

module scoreboard_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dec_vld_0_i,
    input  scb_pkg::exe_sel_t  dec_exe_sel_0_i,
    input  scb_pkg::reg_idx_t  dec_rd_0_i,
    input  scb_pkg::reg_idx_t  dec_rs1_0_i,
    input  scb_pkg::reg_idx_t  dec_rs2_0_i,
    input  logic               dec_vld_1_i,
    input  scb_pkg::exe_sel_t  dec_exe_sel_1_i,
    input  scb_pkg::reg_idx_t  dec_rd_1_i,
    input  scb_pkg::reg_idx_t  dec_rs1_1_i,
    input  scb_pkg::reg_idx_t  dec_rs2_1_i,
    output logic               dec_stall_0_o,
    output logic               dec_flush_0_o,
    output scb_pkg::sid_t      dec_sid_0_o,
    output scb_pkg::unit_vec_t dec_unit_0_o,
    output logic               dec_stall_1_o,
    output logic               dec_flush_1_o,
    output scb_pkg::sid_t      dec_sid_1_o,
    output scb_pkg::unit_vec_t dec_unit_1_o,
    input  logic               op_vld_0_i,
    input  scb_pkg::sid_t      op_sid_0_i,
    input  scb_pkg::reg_idx_t  op_rd_0_i,
    input  scb_pkg::reg_idx_t  op_rs1_0_i,
    input  scb_pkg::reg_idx_t  op_rs2_0_i,
    input  logic               op_vld_1_i,
    input  scb_pkg::sid_t      op_sid_1_i,
    input  scb_pkg::reg_idx_t  op_rd_1_i,
    input  scb_pkg::reg_idx_t  op_rs1_1_i,
    input  scb_pkg::reg_idx_t  op_rs2_1_i,
    output logic               op_stall_0_o,
    output logic               op_flush_0_o,
    output logic               op_stall_1_o,
    output logic               op_flush_1_o,
    input  logic               wb_vld_0_i,
    input  scb_pkg::sid_t      wb_sid_0_i,
    input  logic               wb_vld_1_i,
    input  scb_pkg::sid_t      wb_sid_1_i,
    input  logic               redirect_i,
    input  scb_pkg::sid_t      redirect_sid_i
);

    scb_pkg::unit_vec_t                     busy;
    scb_pkg::reg_idx_t [`SCB_NUM_UNITS-1:0] ent_rd;
    scb_pkg::sid_t     [`SCB_NUM_UNITS-1:0] ent_sid;
    scb_pkg::unit_vec_t                     wr_en;
    scb_pkg::unit_vec_t                     wr_lane;
    scb_pkg::reg_idx_t [1:0]                wr_rd;
    scb_pkg::reg_idx_t [1:0]                wr_rs1;
    scb_pkg::reg_idx_t [1:0]                wr_rs2;
    scb_pkg::sid_t     [1:0]                wr_sid;
    scb_pkg::reg_idx_t [`SCB_NUM_UNITS-1:0] sel_rd;
    scb_pkg::reg_idx_t [`SCB_NUM_UNITS-1:0] sel_rs1;
    scb_pkg::reg_idx_t [`SCB_NUM_UNITS-1:0] sel_rs2;
    scb_pkg::sid_t     [`SCB_NUM_UNITS-1:0] sel_sid;

    scb_issue u_issue (
        .*,
        .busy_i(busy), .ent_rd_i(ent_rd),
        .wr_en_o(wr_en), .wr_lane_o(wr_lane),
        .wr_rd_0_o(wr_rd[0]), .wr_rs1_0_o(wr_rs1[0]),
        .wr_rs2_0_o(wr_rs2[0]), .wr_sid_0_o(wr_sid[0]),
        .wr_rd_1_o(wr_rd[1]), .wr_rs1_1_o(wr_rs1[1]),
        .wr_rs2_1_o(wr_rs2[1]), .wr_sid_1_o(wr_sid[1])
    );

    scb_operand_hazard u_hazard (
        .*,
        .busy_i(busy), .ent_rd_i(ent_rd), .ent_sid_i(ent_sid)
    );

    // each entry loads from the lane steered to it
    for (genvar u = 0; u < `SCB_NUM_UNITS; u++) begin : g_wr_mux
        assign sel_rd[u]  = wr_rd[wr_lane[u]];
        assign sel_rs1[u] = wr_rs1[wr_lane[u]];
        assign sel_rs2[u] = wr_rs2[wr_lane[u]];
        assign sel_sid[u] = wr_sid[wr_lane[u]];
    end

    scb_entry u_alu0 (
        .*,
        .wr_en_i(wr_en[`SCB_U_ALU0]), .wr_rd_i(sel_rd[`SCB_U_ALU0]),
        .wr_rs1_i(sel_rs1[`SCB_U_ALU0]), .wr_rs2_i(sel_rs2[`SCB_U_ALU0]),
        .wr_sid_i(sel_sid[`SCB_U_ALU0]),
        .busy_o(busy[`SCB_U_ALU0]), .rd_o(ent_rd[`SCB_U_ALU0]), .sid_o(ent_sid[`SCB_U_ALU0])
    );

    scb_entry u_alu1 (
        .*,
        .wr_en_i(wr_en[`SCB_U_ALU1]), .wr_rd_i(sel_rd[`SCB_U_ALU1]),
        .wr_rs1_i(sel_rs1[`SCB_U_ALU1]), .wr_rs2_i(sel_rs2[`SCB_U_ALU1]),
        .wr_sid_i(sel_sid[`SCB_U_ALU1]),
        .busy_o(busy[`SCB_U_ALU1]), .rd_o(ent_rd[`SCB_U_ALU1]), .sid_o(ent_sid[`SCB_U_ALU1])
    );

    scb_entry u_beu (
        .*,
        .wr_en_i(wr_en[`SCB_U_BEU]), .wr_rd_i(sel_rd[`SCB_U_BEU]),
        .wr_rs1_i(sel_rs1[`SCB_U_BEU]), .wr_rs2_i(sel_rs2[`SCB_U_BEU]),
        .wr_sid_i(sel_sid[`SCB_U_BEU]),
        .busy_o(busy[`SCB_U_BEU]), .rd_o(ent_rd[`SCB_U_BEU]), .sid_o(ent_sid[`SCB_U_BEU])
    );

    scb_entry u_lsu (
        .*,
        .wr_en_i(wr_en[`SCB_U_LSU]), .wr_rd_i(sel_rd[`SCB_U_LSU]),
        .wr_rs1_i(sel_rs1[`SCB_U_LSU]), .wr_rs2_i(sel_rs2[`SCB_U_LSU]),
        .wr_sid_i(sel_sid[`SCB_U_LSU]),
        .busy_o(busy[`SCB_U_LSU]), .rd_o(ent_rd[`SCB_U_LSU]), .sid_o(ent_sid[`SCB_U_LSU])
    );

endmodule

// ==== include/scb_consts.svh ====
`ifndef SCB_CONSTS_SVH
`define SCB_CONSTS_SVH

// sid index bits, one wrap bit sits above them
`define SCB_SID_IDX_W 3

`define SCB_REG_W 5

// decoder unit select
`define SCB_EXE_SEL_W 6
`define SCB_SEL_ALU   0
`define SCB_SEL_BEU   1
`define SCB_SEL_LSU   2

// one entry per execution slot
`define SCB_NUM_UNITS 4

// bit positions in the unit one-hot vectors
`define SCB_U_ALU0 0
`define SCB_U_ALU1 1
`define SCB_U_BEU  2
`define SCB_U_LSU  3

`endif

// ==== list.f ====
+incdir+include
design/scb_pkg.sv
design/scb_entry.sv
design/scb_issue.sv
design/scb_operand_hazard.sv
design/scoreboard_top.sv
test/scb_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the scoreboard testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module scb_tb -o scb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/scb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx ">>> PASS"; then
    exit 0
fi
exit 1

// ==== test/scb_tb.sv ====
`include "scb_consts.svh"

module scb_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_TESTS       = 5;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 50;

    localparam scb_pkg::exe_sel_t  SEL_ALU = scb_pkg::exe_sel_t'(1 << `SCB_SEL_ALU);
    localparam scb_pkg::exe_sel_t  SEL_BEU = scb_pkg::exe_sel_t'(1 << `SCB_SEL_BEU);
    localparam scb_pkg::exe_sel_t  SEL_LSU = scb_pkg::exe_sel_t'(1 << `SCB_SEL_LSU);
    localparam scb_pkg::unit_vec_t U_ALU0  = scb_pkg::unit_vec_t'(1 << `SCB_U_ALU0);
    localparam scb_pkg::unit_vec_t U_ALU1  = scb_pkg::unit_vec_t'(1 << `SCB_U_ALU1);
    localparam scb_pkg::unit_vec_t U_BEU   = scb_pkg::unit_vec_t'(1 << `SCB_U_BEU);
    localparam scb_pkg::unit_vec_t U_LSU   = scb_pkg::unit_vec_t'(1 << `SCB_U_LSU);

    logic               clk;
    logic               rst_n;
    logic               dec_vld_0_i;
    scb_pkg::exe_sel_t  dec_exe_sel_0_i;
    scb_pkg::reg_idx_t  dec_rd_0_i;
    scb_pkg::reg_idx_t  dec_rs1_0_i;
    scb_pkg::reg_idx_t  dec_rs2_0_i;
    logic               dec_vld_1_i;
    scb_pkg::exe_sel_t  dec_exe_sel_1_i;
    scb_pkg::reg_idx_t  dec_rd_1_i;
    scb_pkg::reg_idx_t  dec_rs1_1_i;
    scb_pkg::reg_idx_t  dec_rs2_1_i;
    logic               dec_stall_0_o;
    logic               dec_flush_0_o;
    scb_pkg::sid_t      dec_sid_0_o;
    scb_pkg::unit_vec_t dec_unit_0_o;
    logic               dec_stall_1_o;
    logic               dec_flush_1_o;
    scb_pkg::sid_t      dec_sid_1_o;
    scb_pkg::unit_vec_t dec_unit_1_o;
    logic               op_vld_0_i;
    scb_pkg::sid_t      op_sid_0_i;
    scb_pkg::reg_idx_t  op_rd_0_i;
    scb_pkg::reg_idx_t  op_rs1_0_i;
    scb_pkg::reg_idx_t  op_rs2_0_i;
    logic               op_vld_1_i;
    scb_pkg::sid_t      op_sid_1_i;
    scb_pkg::reg_idx_t  op_rd_1_i;
    scb_pkg::reg_idx_t  op_rs1_1_i;
    scb_pkg::reg_idx_t  op_rs2_1_i;
    logic               op_stall_0_o;
    logic               op_flush_0_o;
    logic               op_stall_1_o;
    logic               op_flush_1_o;
    logic               wb_vld_0_i;
    scb_pkg::sid_t      wb_sid_0_i;
    logic               wb_vld_1_i;
    scb_pkg::sid_t      wb_sid_1_i;
    logic               redirect_i;
    scb_pkg::sid_t      redirect_sid_i;

    int                 errors;
    int                 checks;
    int                 tests_failed;
    // model of the sid counter, steps by accepted instructions
    scb_pkg::sid_t      exp_sid;
    logic [31:0]        used_regs;

    scoreboard_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s at %0t: got 0x%0h, expected 0x%0h", name, $time, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_at_start);
        if (errors == err_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d check(s) failed", name, errors - err_at_start);
            tests_failed++;
        end
    endtask

    // distinct register per call within a test, never x0
    task automatic fresh_reg(output scb_pkg::reg_idx_t r);
        r = scb_pkg::reg_idx_t'($urandom_range(31, 1));
        while (used_regs[r]) begin
            r = scb_pkg::reg_idx_t'($urandom_range(31, 1));
        end
        used_regs[r] = 1'b1;
    endtask

    task automatic drive_dec(input int lane, input logic vld, input scb_pkg::exe_sel_t sel,
                             input scb_pkg::reg_idx_t rd);
        if (lane == 0) begin
            dec_vld_0_i     <= vld;
            dec_exe_sel_0_i <= sel;
            dec_rd_0_i      <= rd;
        end else begin
            dec_vld_1_i     <= vld;
            dec_exe_sel_1_i <= sel;
            dec_rd_1_i      <= rd;
        end
    endtask

    task automatic drive_op(input int lane, input logic vld, input scb_pkg::sid_t sid,
                            input scb_pkg::reg_idx_t rd, input scb_pkg::reg_idx_t rs1,
                            input scb_pkg::reg_idx_t rs2);
        if (lane == 0) begin
            op_vld_0_i <= vld;
            op_sid_0_i <= sid;
            op_rd_0_i  <= rd;
            op_rs1_0_i <= rs1;
            op_rs2_0_i <= rs2;
        end else begin
            op_vld_1_i <= vld;
            op_sid_1_i <= sid;
            op_rd_1_i  <= rd;
            op_rs1_1_i <= rs1;
            op_rs2_1_i <= rs2;
        end
    endtask

    task automatic idle_inputs();
        dec_vld_0_i <= 1'b0;
        dec_vld_1_i <= 1'b0;
        op_vld_0_i  <= 1'b0;
        op_vld_1_i  <= 1'b0;
        wb_vld_0_i  <= 1'b0;
        wb_vld_1_i  <= 1'b0;
        redirect_i  <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        idle_inputs();
        repeat (2) @(posedge clk);
        rst_n     <= 1'b1;
        exp_sid   = '0;
        used_regs = '0;
    endtask

    // both lanes accepted in one cycle, then the decoder goes idle
    task automatic issue_two(input scb_pkg::exe_sel_t sel0, input scb_pkg::reg_idx_t rd0,
                             input scb_pkg::unit_vec_t unit0, input scb_pkg::exe_sel_t sel1,
                             input scb_pkg::reg_idx_t rd1, input scb_pkg::unit_vec_t unit1);
        @(posedge clk);
        drive_dec(0, 1'b1, sel0, rd0);
        drive_dec(1, 1'b1, sel1, rd1);
        @(negedge clk);
        check("dec_stall_0_o", 32'(dec_stall_0_o), 32'd0);
        check("dec_stall_1_o", 32'(dec_stall_1_o), 32'd0);
        check("dec_sid_0_o", 32'(dec_sid_0_o), 32'(exp_sid));
        check("dec_sid_1_o", 32'(dec_sid_1_o), 32'(exp_sid + 4'd1));
        check("dec_unit_0_o", 32'(dec_unit_0_o), 32'(unit0));
        check("dec_unit_1_o", 32'(dec_unit_1_o), 32'(unit1));
        exp_sid = exp_sid + 4'd2;
        @(posedge clk);
        dec_vld_0_i <= 1'b0;
        dec_vld_1_i <= 1'b0;
    endtask

    task automatic write_back(input logic v0, input scb_pkg::sid_t s0,
                              input logic v1, input scb_pkg::sid_t s1);
        @(posedge clk);
        wb_vld_0_i <= v0;
        wb_sid_0_i <= s0;
        wb_vld_1_i <= v1;
        wb_sid_1_i <= s1;
        @(posedge clk);
        wb_vld_0_i <= 1'b0;
        wb_vld_1_i <= 1'b0;
    endtask

    task automatic test_sid_issue();
        int                err_at_start;
        scb_pkg::reg_idx_t ra;
        scb_pkg::reg_idx_t rb;
        err_at_start = errors;
        apply_reset();
        fresh_reg(ra);
        fresh_reg(rb);
        @(negedge clk);
        check("dec_flush_0_o", 32'(dec_flush_0_o), 32'd0);
        check("dec_flush_1_o", 32'(dec_flush_1_o), 32'd0);
        check("op_stall_0_o", 32'(op_stall_0_o), 32'd0);
        check("op_flush_1_o", 32'(op_flush_1_o), 32'd0);
        issue_two(SEL_ALU, ra, U_ALU0, SEL_ALU, rb, U_ALU1);
        @(negedge clk);
        check("dec_sid_0_o", 32'(dec_sid_0_o), 32'd2);
        check("dec_sid_1_o", 32'(dec_sid_1_o), 32'd3);
        finish_test("sid_issue", err_at_start);
    endtask

    task automatic test_unit_full();
        int                err_at_start;
        scb_pkg::reg_idx_t ra;
        scb_pkg::reg_idx_t rb;
        scb_pkg::reg_idx_t rc;
        scb_pkg::reg_idx_t rd;
        err_at_start = errors;
        apply_reset();
        fresh_reg(ra);
        fresh_reg(rb);
        fresh_reg(rc);
        fresh_reg(rd);
        issue_two(SEL_ALU, ra, U_ALU0, SEL_ALU, rb, U_ALU1);
        @(posedge clk);
        drive_dec(0, 1'b1, SEL_ALU, rc);
        @(negedge clk);
        check("dec_stall_0_o", 32'(dec_stall_0_o), 32'd1);
        check("dec_unit_0_o", 32'(dec_unit_0_o), 32'd0);
        // beu is free, rd collides with alu0
        @(posedge clk);
        drive_dec(0, 1'b1, SEL_BEU, ra);
        @(negedge clk);
        check("dec_stall_0_o", 32'(dec_stall_0_o), 32'd1);
        @(posedge clk);
        drive_dec(0, 1'b1, SEL_BEU, rd);
        @(negedge clk);
        check("dec_stall_0_o", 32'(dec_stall_0_o), 32'd0);
        check("dec_unit_0_o", 32'(dec_unit_0_o), 32'(U_BEU));
        check("dec_sid_0_o", 32'(dec_sid_0_o), 32'(exp_sid));
        exp_sid = exp_sid + 4'd1;
        @(posedge clk);
        dec_vld_0_i <= 1'b0;
        @(negedge clk);
        check("dec_sid_0_o", 32'(dec_sid_0_o), 32'(exp_sid));
        finish_test("unit_full_waw", err_at_start);
    endtask

    task automatic test_writeback();
        int                err_at_start;
        scb_pkg::sid_t     base;
        scb_pkg::reg_idx_t ra;
        scb_pkg::reg_idx_t rb;
        scb_pkg::reg_idx_t rc;
        err_at_start = errors;
        apply_reset();
        fresh_reg(ra);
        fresh_reg(rb);
        fresh_reg(rc);
        base = exp_sid;
        issue_two(SEL_ALU, ra, U_ALU0, SEL_ALU, rb, U_ALU1);
        write_back(1'b1, base, 1'b0, '0);
        @(posedge clk);
        drive_dec(0, 1'b1, SEL_ALU, rc);
        @(negedge clk);
        check("dec_stall_0_o", 32'(dec_stall_0_o), 32'd0);
        check("dec_unit_0_o", 32'(dec_unit_0_o), 32'(U_ALU0));
        check("dec_sid_0_o", 32'(dec_sid_0_o), 32'(exp_sid));
        exp_sid = exp_sid + 4'd1;
        @(posedge clk);
        dec_vld_0_i <= 1'b0;
        finish_test("writeback", err_at_start);
    endtask

    task automatic test_operand_raw();
        int                err_at_start;
        scb_pkg::reg_idx_t ra;
        scb_pkg::reg_idx_t rb;
        scb_pkg::reg_idx_t rc;
        scb_pkg::reg_idx_t rx;
        scb_pkg::reg_idx_t ry;
        err_at_start = errors;
        apply_reset();
        fresh_reg(ra);
        fresh_reg(rb);
        fresh_reg(rc);
        fresh_reg(rx);
        fresh_reg(ry);
        // alu0 holds sid 0 writing ra, alu1 holds sid 1 writing rb
        issue_two(SEL_ALU, ra, U_ALU0, SEL_ALU, rb, U_ALU1);
        @(posedge clk);
        drive_op(0, 1'b1, 4'd2, rx, ra, ry);
        @(negedge clk);
        check("op_stall_0_o", 32'(op_stall_0_o), 32'd1);
        @(posedge clk);
        drive_op(0, 1'b1, 4'd0, rx, rb, ry);
        @(negedge clk);
        check("op_stall_0_o", 32'(op_stall_0_o), 32'd0);
        // lane 1 writes lane 0's rs1 but is the younger one
        @(posedge clk);
        drive_op(0, 1'b1, 4'd2, rc, rx, ry);
        drive_op(1, 1'b1, 4'd3, rx, rc, ry);
        @(negedge clk);
        check("op_stall_0_o", 32'(op_stall_0_o), 32'd0);
        check("op_stall_1_o", 32'(op_stall_1_o), 32'd1);
        @(posedge clk);
        op_vld_0_i <= 1'b0;
        op_vld_1_i <= 1'b0;
        finish_test("operand_raw", err_at_start);
    endtask

    // fills all four slots from the current sid, then redirects at base+1
    task automatic redirect_case();
        scb_pkg::sid_t     base;
        scb_pkg::reg_idx_t ra;
        scb_pkg::reg_idx_t rb;
        scb_pkg::reg_idx_t rc;
        scb_pkg::reg_idx_t rd;
        scb_pkg::reg_idx_t rx;
        scb_pkg::reg_idx_t ry;
        base = exp_sid;
        fresh_reg(ra);
        fresh_reg(rb);
        fresh_reg(rc);
        fresh_reg(rd);
        fresh_reg(rx);
        fresh_reg(ry);
        issue_two(SEL_ALU, ra, U_ALU0, SEL_ALU, rb, U_ALU1);
        issue_two(SEL_BEU, rc, U_BEU, SEL_LSU, rd, U_LSU);
        @(posedge clk);
        redirect_i     <= 1'b1;
        redirect_sid_i <= base + 4'd1;
        drive_op(0, 1'b0, base + 4'd2, '0, '0, '0);
        drive_op(1, 1'b0, base + 4'd3, '0, '0, '0);
        @(negedge clk);
        check("op_flush_0_o", 32'(op_flush_0_o), 32'd1);
        check("op_flush_1_o", 32'(op_flush_1_o), 32'd1);
        check("dec_flush_0_o", 32'(dec_flush_0_o), 32'd1);
        check("dec_flush_1_o", 32'(dec_flush_1_o), 32'd1);
        @(posedge clk);
        drive_op(0, 1'b0, base, '0, '0, '0);
        drive_op(1, 1'b0, base + 4'd1, '0, '0, '0);
        @(negedge clk);
        check("op_flush_0_o", 32'(op_flush_0_o), 32'd0);
        check("op_flush_1_o", 32'(op_flush_1_o), 32'd0);
        // lane 0 probes the alu entries, lane 1 the flushed ones
        @(posedge clk);
        redirect_i <= 1'b0;
        drive_op(0, 1'b1, base + 4'd4, rx, ra, rx);
        drive_op(1, 1'b1, base + 4'd5, ry, rc, ry);
        @(negedge clk);
        check("op_stall_0_o", 32'(op_stall_0_o), 32'd1);
        check("op_stall_1_o", 32'(op_stall_1_o), 32'd0);
        @(posedge clk);
        drive_op(0, 1'b1, base + 4'd4, rx, rb, rx);
        drive_op(1, 1'b1, base + 4'd5, ry, rd, ry);
        @(negedge clk);
        check("op_stall_0_o", 32'(op_stall_0_o), 32'd1);
        check("op_stall_1_o", 32'(op_stall_1_o), 32'd0);
        @(posedge clk);
        op_vld_0_i <= 1'b0;
        op_vld_1_i <= 1'b0;
    endtask

    task automatic test_redirect();
        int                err_at_start;
        scb_pkg::reg_idx_t ra;
        scb_pkg::reg_idx_t rb;
        err_at_start = errors;
        apply_reset();
        redirect_case();
        // sids 6 and 7 stay, 8 and 9 sit across the wrap bit
        apply_reset();
        fresh_reg(ra);
        fresh_reg(rb);
        repeat (3) begin
            issue_two(SEL_ALU, ra, U_ALU0, SEL_ALU, rb, U_ALU1);
            write_back(1'b1, exp_sid - 4'd2, 1'b1, exp_sid - 4'd1);
        end
        redirect_case();
        finish_test("redirect_flush", err_at_start);
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        tests_failed = 0;
        exp_sid      = '0;
        used_regs    = '0;
        void'($urandom(32'h4469));
        rst_n           <= 1'b0;
        dec_exe_sel_0_i <= '0;
        dec_rd_0_i      <= '0;
        dec_rs1_0_i     <= '0;
        dec_rs2_0_i     <= '0;
        dec_exe_sel_1_i <= '0;
        dec_rd_1_i      <= '0;
        dec_rs1_1_i     <= '0;
        dec_rs2_1_i     <= '0;
        op_sid_0_i      <= '0;
        op_rd_0_i       <= '0;
        op_rs1_0_i      <= '0;
        op_rs2_0_i      <= '0;
        op_sid_1_i      <= '0;
        op_rd_1_i       <= '0;
        op_rs1_1_i      <= '0;
        op_rs2_1_i      <= '0;
        wb_sid_0_i      <= '0;
        wb_sid_1_i      <= '0;
        redirect_sid_i  <= '0;
        idle_inputs();

        test_sid_issue();
        test_unit_full();
        test_writeback();
        test_operand_raw();
        test_redirect();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 NUM_TESTS, tests_failed, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
